// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary -j 0 -Wno-fatal --top-module tb_rmt_pipeline \
		-f rmt_pipeline.f -o tb_rmt_pipeline
	./obj_dir/tb_rmt_pipeline | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_rmt_pipeline.sv ====
`timescale 1ns/10ps

module tb_rmt_pipeline
	import rmt_hdr_pkg::*;
	import rmt_table_pkg::*;
();

	logic clk;
	logic aresetn;
	logic [2**vlan_idx_w-1:0] vlan_drop_flags;
	rmt_word_t s_axis_tdata;
	logic s_axis_tvalid;
	logic s_axis_tready;
	logic s_axis_tlast;
	rmt_word_t m_axis_tdata;
	logic m_axis_tvalid;
	logic m_axis_tready;
	logic m_axis_tlast;

	// reference tables, one row per stage
	logic mdl_valid [num_stages][tbl_depth];
	logic [key_w-1:0] mdl_key [num_stages][tbl_depth];
	logic [cont_w-1:0] mdl_value [num_stages][tbl_depth];
	// expected output beats, oldest first
	rmt_word_t exp_data [$];
	logic exp_last [$];
	bit exp_is_hdr [$];
	// input framing as the model sees it
	logic in_first;
	logic in_discard;

	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int hits [num_stages];
	int dropped;
	int stalls;
	// output ready low when urandom % 4 is below this
	int stall_level;
	bit timed_out;
	logic ready_now;
	// beat seen with ready low, must still be there next cycle
	logic held_valid;
	rmt_word_t held_data;

	rmt_pipeline dut0 (
		.clk(clk),
		.aresetn(aresetn),
		.vlan_drop_flags(vlan_drop_flags),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tready(s_axis_tready),
		.s_axis_tlast(s_axis_tlast),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready),
		.m_axis_tlast(m_axis_tlast)
	);

	// 4 ns period
	always #2 clk = ~clk;

	task automatic compare_hdr(input string name, input rmt_hdr_u got, input rmt_hdr_u exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_word(input string name, input rmt_word_t got, input rmt_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic compare_last(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR: %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	// lowest valid index with a matching key wins
	function automatic logic table_lookup(input int stage, input logic [key_w-1:0] key,
			output logic [cont_w-1:0] value);
		logic found;
		found = 1'b0;
		value = '0;
		for (int i = 0; i < tbl_depth; i++) begin
			if (!found && mdl_valid[stage][i] && mdl_key[stage][i] == key) begin
				found = 1'b1;
				value = mdl_value[stage][i];
			end
		end
		return found;
	endfunction

	// one accepted input beat through filter, tables and stages
	function automatic void model_accept(input rmt_word_t w, input logic last);
		rmt_hdr_u h;
		logic [cont_w-1:0] v;
		h = w;
		if (in_first) begin
			if (h.data.kind) begin
				// control header, table write, packet never leaves
				mdl_valid[h.ctrl.stage_sel][h.ctrl.idx] = h.ctrl.valid;
				mdl_key[h.ctrl.stage_sel][h.ctrl.idx] = h.ctrl.key;
				mdl_value[h.ctrl.stage_sel][h.ctrl.idx] = h.ctrl.value;
				in_discard = 1'b1;
			end else if (vlan_drop_flags[h.data.vlan_idx]) begin
				in_discard = 1'b1;
				dropped++;
			end else begin
				in_discard = 1'b0;
				// stage n rewrites container n
				if (table_lookup(0, h.data.key, v)) begin
					h.data.cont0 = v;
					hits[0]++;
				end
				if (table_lookup(1, h.data.key, v)) begin
					h.data.cont1 = v;
					hits[1]++;
				end
				exp_data.push_back(h);
				exp_last.push_back(last);
				exp_is_hdr.push_back(1'b1);
			end
		end else if (!in_discard) begin
			exp_data.push_back(w);
			exp_last.push_back(last);
			exp_is_hdr.push_back(1'b0);
		end
		in_first = last;
	endfunction

	task automatic check_beat();
		rmt_word_t want;
		logic want_last;
		bit want_hdr;
		if (exp_data.size() == 0) begin
			errors++;
			$display("unexpected output beat with nothing expected, tdata 0x%h", m_axis_tdata);
		end else begin
			want = exp_data.pop_front();
			want_last = exp_last.pop_front();
			want_hdr = exp_is_hdr.pop_front();
			if (want_hdr)
				compare_hdr("m_axis_tdata", m_axis_tdata, want);
			else
				compare_word("m_axis_tdata", m_axis_tdata, want);
			compare_last("m_axis_tlast", m_axis_tlast, want_last);
		end
	endtask

	// output side, valid and data settle after the rising edge
	always @(negedge clk) begin
		if (aresetn) begin
			if (held_valid) begin
				if (!m_axis_tvalid) begin
					errors++;
					$display("m_axis_tvalid dropped before a stalled beat was taken");
				end else begin
					compare_word("m_axis_tdata", m_axis_tdata, held_data);
				end
			end
			ready_now = ($urandom % 4) >= stall_level;
			m_axis_tready = ready_now;
			// transfer happens on the next rising edge
			if (m_axis_tvalid && ready_now)
				check_beat();
			held_valid = m_axis_tvalid && !ready_now;
			held_data = m_axis_tdata;
		end
	end

	// called on a falling edge, returns on a falling edge
	task automatic drive_beat(input rmt_word_t data, input logic last);
		int wait_cycles;
		if (timed_out)
			return;
		s_axis_tdata = data;
		s_axis_tlast = last;
		s_axis_tvalid = 1'b1;
		wait_cycles = 0;
		// tready only follows fifo fill, so stable over the low phase
		while (!s_axis_tready && !timed_out) begin
			stalls++;
			@(negedge clk);
			wait_cycles++;
			if (wait_cycles > 1000) begin
				$display("timeout: s_axis_tready stayed low for 1000 cycles");
				timed_out = 1'b1;
			end
		end
		if (!timed_out)
			model_accept(data, last);
		@(negedge clk);
		// next beat may follow in the same step, so no gap
		s_axis_tvalid = 1'b0;
	endtask

	task automatic send_packet(input rmt_word_t hdr, input int beats);
		drive_beat(hdr, beats == 1);
		for (int i = 1; i < beats; i++)
			drive_beat({$urandom, $urandom}, i == beats - 1);
	endtask

	// small key set, so hits are frequent
	function automatic logic [key_w-1:0] pick_key();
		return 8'ha0 + 8'($urandom % 4);
	endfunction

	task automatic send_data(input int beats);
		rmt_hdr_u h;
		h = {$urandom, $urandom};
		h.data.kind = 1'b0;
		h.data.key = pick_key();
		send_packet(h, beats);
	endtask

	task automatic send_ctrl(input logic stage, input logic [tbl_idx_w-1:0] idx,
			input logic valid, input logic [key_w-1:0] key, input logic [cont_w-1:0] value);
		rmt_hdr_u h;
		h = {$urandom, $urandom};
		h.ctrl.kind = 1'b1;
		h.ctrl.stage_sel = stage;
		h.ctrl.idx = idx;
		h.ctrl.valid = valid;
		h.ctrl.key = key;
		h.ctrl.value = value;
		// trailing beat is thrown away by the filter
		send_packet(h, 1 + $urandom % 2);
	endtask

	// expected queue empty, then a few quiet cycles for stray beats
	task automatic wait_drain();
		int wait_cycles;
		int quiet;
		wait_cycles = 0;
		quiet = 0;
		while (quiet < 8 && !timed_out) begin
			@(negedge clk);
			wait_cycles++;
			if (exp_data.size() == 0)
				quiet++;
			else
				quiet = 0;
			if (wait_cycles > 5000) begin
				$display("timeout: %0d expected beats never came out", exp_data.size());
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (errors != errs_before || timed_out) begin
			tests_failed++;
			$display("test %s: failed, %0d errors", name, errors - errs_before);
		end else begin
			$display("test %s: passed", name);
		end
	endtask

	initial begin
		int start;
		void'($urandom(32'h7d587498));
		clk = 1'b0;
		aresetn = 1'b0;
		vlan_drop_flags = '0;
		s_axis_tdata = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tlast = 1'b0;
		m_axis_tready = 1'b0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		hits[0] = 0;
		hits[1] = 0;
		dropped = 0;
		stalls = 0;
		stall_level = 1;
		timed_out = 1'b0;
		in_first = 1'b1;
		in_discard = 1'b0;
		held_valid = 1'b0;
		foreach (mdl_valid[s, i])
			mdl_valid[s][i] = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		aresetn = 1'b1;

		// idle outputs right after reset, first packet untouched
		start = errors;
		@(negedge clk);
		if (m_axis_tvalid !== 1'b0) begin
			errors++;
			$display("ERROR: m_axis_tvalid got 0x%h expected 0x0", m_axis_tvalid);
		end
		if (s_axis_tready !== 1'b1) begin
			errors++;
			$display("ERROR: s_axis_tready got 0x%h expected 0x1", s_axis_tready);
		end
		send_data(1 + $urandom % 4);
		wait_drain();
		end_test("reset_state", start);

		// empty tables, packets pass unchanged
		start = errors;
		repeat (20) send_data(1 + $urandom % 4);
		wait_drain();
		end_test("pass_through", start);

		// both stages written, key a3 only in stage 0
		start = errors;
		for (int i = 0; i < 4; i++) begin
			send_ctrl(1'b0, 3'(i), 1'b1, 8'ha0 + 8'(i), 16'($urandom));
			if (i < 3)
				send_ctrl(1'b1, 3'(i + 2), 1'b1, 8'ha0 + 8'(i), 16'($urandom));
		end
		// same key at a higher index, loses to index 0
		send_ctrl(1'b0, 3'd7, 1'b1, 8'ha0, 16'($urandom));
		repeat (30) send_data(1 + $urandom % 4);
		wait_drain();
		if (hits[0] == 0 || hits[1] == 0) begin
			errors++;
			$display("no header hit a table entry in one of the stages");
		end
		end_test("table_hit", start);

		// flags change only with the pipeline empty
		start = errors;
		dropped = 0;
		vlan_drop_flags = 16'($urandom) | 16'h0001;
		repeat (40) begin
			if ($urandom % 4 == 0)
				send_ctrl(1'($urandom % 2), 3'($urandom), 1'($urandom % 2), pick_key(),
					16'($urandom));
			else
				send_data(1 + $urandom % 4);
		end
		wait_drain();
		if (dropped == 0) begin
			errors++;
			$display("no packet was dropped by vlan_drop_flags");
		end
		end_test("vlan_drop", start);

		// every entry of both tables cleared
		start = errors;
		vlan_drop_flags = '0;
		for (int s = 0; s < num_stages; s++)
			for (int i = 0; i < tbl_depth; i++)
				send_ctrl(1'(s), 3'(i), 1'b0, 8'ha0 + 8'(i % 4), 16'($urandom));
		repeat (20) send_data(1 + $urandom % 4);
		wait_drain();
		end_test("invalidate", start);

		// long bursts against a mostly stalled output
		start = errors;
		send_ctrl(1'b0, 3'd1, 1'b1, 8'ha1, 16'($urandom));
		send_ctrl(1'b1, 3'd4, 1'b1, 8'ha2, 16'($urandom));
		stalls = 0;
		stall_level = 3;
		repeat (30) send_data(4);
		stall_level = 1;
		wait_drain();
		if (stalls == 0) begin
			errors++;
			$display("s_axis_tready never went low, the fifos did not fill");
		end
		end_test("back_pressure", start);

		$display("tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0 && !timed_out) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== rmt_pipeline.f ====
verilog/rmt_table_pkg.sv
verilog/rmt_hdr_pkg.sv
verilog/sync_fifo.sv
verilog/match_table.sv
verilog/match_action_stage.sv
verilog/pkt_filter.sv
verilog/phv_deparser.sv
verilog/rmt_pipeline.sv
bench/tb_rmt_pipeline.sv

// ==== verilog/match_action_stage.sv ====
`timescale 1ns/10ps

module match_action_stage
	import rmt_hdr_pkg::*;
	import rmt_table_pkg::*;
#(
	parameter int STAGE_ID = 0
) (
	input  logic clk,
	input  logic aresetn,

	input  logic phv_in_valid,
	input  rmt_hdr_u phv_in,
	output logic phv_out_valid,
	output rmt_hdr_u phv_out,

	input  logic tbl_wr_en,
	input  logic tbl_wr_stage,
	input  logic [tbl_idx_w-1:0] tbl_wr_idx,
	input  logic tbl_wr_valid,
	input  logic [key_w-1:0] tbl_wr_key,
	input  logic [cont_w-1:0] tbl_wr_value
);

	logic hit;
	logic [cont_w-1:0] hit_value;
	rmt_hdr_u phv_next;

	// own table, looked up with the key of the incoming phv
	match_table #(
		.STAGE_ID(STAGE_ID)
	) table0 (
		.clk(clk),
		.aresetn(aresetn),
		.tbl_wr_en(tbl_wr_en),
		.tbl_wr_stage(tbl_wr_stage),
		.tbl_wr_idx(tbl_wr_idx),
		.tbl_wr_valid(tbl_wr_valid),
		.tbl_wr_key(tbl_wr_key),
		.tbl_wr_value(tbl_wr_value),
		.lookup_key(phv_in.data.key),
		.hit(hit),
		.hit_value(hit_value)
	);

	// action, stage n owns container n
	always_comb begin
		phv_next = phv_in;
		if (hit) begin
			if (STAGE_ID == 0)
				phv_next.data.cont0 = hit_value;
			else
				phv_next.data.cont1 = hit_value;
		end
	end

	// one cycle per stage, no stall
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn)
			phv_out_valid <= 1'b0;
		else
			phv_out_valid <= phv_in_valid;
	end

	always_ff @(posedge clk) begin
		if (phv_in_valid)
			phv_out <= phv_next;
	end

endmodule

// ==== verilog/match_table.sv ====
`timescale 1ns/10ps

module match_table
	import rmt_hdr_pkg::*;
	import rmt_table_pkg::*;
#(
	parameter int STAGE_ID = 0
) (
	input  logic clk,
	input  logic aresetn,
	input  logic tbl_wr_en,
	input  logic tbl_wr_stage,
	input  logic [tbl_idx_w-1:0] tbl_wr_idx,
	input  logic tbl_wr_valid,
	input  logic [key_w-1:0] tbl_wr_key,
	input  logic [cont_w-1:0] tbl_wr_value,
	input  logic [key_w-1:0] lookup_key,
	output logic hit,
	output logic [cont_w-1:0] hit_value
);

	logic ent_valid [tbl_depth];
	logic [key_w-1:0] ent_key [tbl_depth];
	logic [cont_w-1:0] ent_value [tbl_depth];
	logic wr_here;

	// strobe is broadcast, keep only writes for this stage
	assign wr_here = tbl_wr_en && (tbl_wr_stage == 1'(STAGE_ID));

	// valid bits cleared on reset, all entries start invalid
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			for (int i = 0; i < tbl_depth; i++)
				ent_valid[i] <= 1'b0;
		end else if (wr_here) begin
			ent_valid[tbl_wr_idx] <= tbl_wr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_here) begin
			ent_key[tbl_wr_idx] <= tbl_wr_key;
			ent_value[tbl_wr_idx] <= tbl_wr_value;
		end
	end

	// parallel compare, scanned from the top so the lowest index wins
	always_comb begin
		hit = 1'b0;
		hit_value = '0;
		for (int i = tbl_depth - 1; i >= 0; i--) begin
			if (ent_valid[i] && (ent_key[i] == lookup_key)) begin
				hit = 1'b1;
				hit_value = ent_value[i];
			end
		end
	end

endmodule

// ==== verilog/phv_deparser.sv ====
`timescale 1ns/10ps

module phv_deparser
	import rmt_hdr_pkg::*;
(
	input  logic clk,
	input  logic aresetn,

	// packet fifo head, tlast on the top bit
	input  logic [word_w:0] pkt_rd_data,
	input  logic pkt_empty,
	output logic pkt_rd_en,

	input  rmt_word_t phv_rd_data,
	input  logic phv_empty,
	output logic phv_rd_en,

	output rmt_word_t m_axis_tdata,
	output logic m_axis_tvalid,
	input  logic m_axis_tready,
	output logic m_axis_tlast
);

	// next beat out is a header
	logic hdr_pending;
	logic xfer;

	assign xfer = m_axis_tvalid && m_axis_tready;
	assign m_axis_tlast = pkt_rd_data[word_w];

	// header beat needs both fifos, body beats only the packet fifo
	always_comb begin
		if (hdr_pending) begin
			m_axis_tvalid = !pkt_empty && !phv_empty;
			// modified header replaces the original first beat
			m_axis_tdata = phv_rd_data;
			phv_rd_en = xfer;
		end else begin
			m_axis_tvalid = !pkt_empty;
			m_axis_tdata = pkt_rd_data[word_w-1:0];
			phv_rd_en = 1'b0;
		end
		// original header popped and discarded alongside the phv
		pkt_rd_en = xfer;
	end

	// back to header after the last beat
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn)
			hdr_pending <= 1'b1;
		else if (xfer)
			hdr_pending <= m_axis_tlast;
	end

endmodule

// ==== verilog/pkt_filter.sv ====
`timescale 1ns/10ps

module pkt_filter
	import rmt_hdr_pkg::*;
	import rmt_table_pkg::*;
(
	input  logic clk,
	input  logic aresetn,
	input  logic [2**vlan_idx_w-1:0] vlan_drop_flags,

	input  rmt_word_t s_axis_tdata,
	input  logic s_axis_tvalid,
	output logic s_axis_tready,
	input  logic s_axis_tlast,

	input  logic pkt_nearly_full,
	input  logic phv_nearly_full,

	output logic pkt_wr_en,
	output logic [word_w:0] pkt_wr_data,
	output logic phv_valid,
	output rmt_hdr_u phv_data,

	output logic tbl_wr_en,
	output logic tbl_wr_stage,
	output logic [tbl_idx_w-1:0] tbl_wr_idx,
	output logic tbl_wr_valid,
	output logic [key_w-1:0] tbl_wr_key,
	output logic [cont_w-1:0] tbl_wr_value
);

	// next accepted beat is a header
	logic first_beat;
	// rest of current packet is thrown away
	logic discard;
	logic accept;
	rmt_hdr_u hdr;
	logic is_ctrl;
	logic hdr_drop;

	// only stall source, both fifos keep slack for phvs in flight
	assign s_axis_tready = !(pkt_nearly_full || phv_nearly_full);
	assign accept = s_axis_tvalid && s_axis_tready;

	// header decode, only meaningful on the first beat
	assign hdr = s_axis_tdata;
	assign is_ctrl = hdr.data.kind;
	assign hdr_drop = is_ctrl || vlan_drop_flags[hdr.data.vlan_idx];

	// kept beats go to packet fifo with tlast on top
	assign pkt_wr_en = accept && (first_beat ? !hdr_drop : !discard);
	assign pkt_wr_data = {s_axis_tlast, s_axis_tdata};

	// kept header starts a phv into stage 0
	assign phv_valid = accept && first_beat && !hdr_drop;
	assign phv_data = hdr;

	// control header writes one table entry
	// stage select passed as is, each table checks its own
	assign tbl_wr_en = accept && first_beat && is_ctrl;
	assign tbl_wr_stage = hdr.ctrl.stage_sel;
	assign tbl_wr_idx = hdr.ctrl.idx;
	assign tbl_wr_valid = hdr.ctrl.valid;
	assign tbl_wr_key = hdr.ctrl.key;
	assign tbl_wr_value = hdr.ctrl.value;

	// packet framing
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			first_beat <= 1'b1;
			discard <= 1'b0;
		end else if (accept) begin
			first_beat <= s_axis_tlast;
			// drop decision latched on the header beat
			if (first_beat)
				discard <= hdr_drop;
		end
	end

endmodule

// ==== verilog/rmt_hdr_pkg.sv ====
package rmt_hdr_pkg;

	// entry index width of the control view comes from the table sizes
	import rmt_table_pkg::*;

	// stream beat
	localparam int word_w = 64;
	// vlan index, selects one bit of vlan_drop_flags
	localparam int vlan_idx_w = 4;
	// match key and container widths
	localparam int key_w = 8;
	localparam int cont_w = 16;

	typedef logic [word_w-1:0] rmt_word_t;

	// data header, kind bit low
	typedef struct packed {
		logic kind;
		logic [vlan_idx_w-1:0] vlan_idx;
		logic [key_w-1:0] key;
		logic [cont_w-1:0] cont0;
		logic [cont_w-1:0] cont1;
		logic [word_w-1-vlan_idx_w-key_w-2*cont_w-1:0] pad;
	} rmt_data_hdr_t;

	// control header, kind bit high, carries one table entry
	typedef struct packed {
		logic kind;
		logic stage_sel;
		logic [tbl_idx_w-1:0] idx;
		logic valid;
		logic [key_w-1:0] key;
		logic [cont_w-1:0] value;
		logic [word_w-2-tbl_idx_w-1-key_w-cont_w-1:0] pad;
	} rmt_ctrl_hdr_t;

	// same header beat, two decodings, kind sits on the top bit of both
	typedef union packed {
		rmt_data_hdr_t data;
		rmt_ctrl_hdr_t ctrl;
	} rmt_hdr_u;

endpackage

// ==== verilog/rmt_pipeline.sv ====
`timescale 1ns/10ps

module rmt_pipeline
	import rmt_hdr_pkg::*;
	import rmt_table_pkg::*;
(
	input  logic clk,
	input  logic aresetn,
	input  logic [2**vlan_idx_w-1:0] vlan_drop_flags,

	input  rmt_word_t s_axis_tdata,
	input  logic s_axis_tvalid,
	output logic s_axis_tready,
	input  logic s_axis_tlast,

	output rmt_word_t m_axis_tdata,
	output logic m_axis_tvalid,
	input  logic m_axis_tready,
	output logic m_axis_tlast
);

	// packet fifo
	logic pkt_wr_en;
	logic [word_w:0] pkt_wr_data;
	logic pkt_rd_en;
	logic [word_w:0] pkt_rd_data;
	logic pkt_empty;
	logic pkt_nearly_full;
	// phv fifo
	logic phv_rd_en;
	rmt_word_t phv_rd_data;
	logic phv_empty;
	logic phv_nearly_full;
	// table write strobe, broadcast to all stages
	logic tbl_wr_en;
	logic tbl_wr_stage;
	logic [tbl_idx_w-1:0] tbl_wr_idx;
	logic tbl_wr_valid;
	logic [key_w-1:0] tbl_wr_key;
	logic [cont_w-1:0] tbl_wr_value;
	// phv chain, entry 0 from filter, last entry into the phv fifo
	logic stg_valid [num_stages+1];
	rmt_hdr_u stg_phv [num_stages+1];

	pkt_filter filter0 (
		.clk(clk),
		.aresetn(aresetn),
		.vlan_drop_flags(vlan_drop_flags),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tready(s_axis_tready),
		.s_axis_tlast(s_axis_tlast),
		.pkt_nearly_full(pkt_nearly_full),
		.phv_nearly_full(phv_nearly_full),
		.pkt_wr_en(pkt_wr_en),
		.pkt_wr_data(pkt_wr_data),
		.phv_valid(stg_valid[0]),
		.phv_data(stg_phv[0]),
		.tbl_wr_en(tbl_wr_en),
		.tbl_wr_stage(tbl_wr_stage),
		.tbl_wr_idx(tbl_wr_idx),
		.tbl_wr_valid(tbl_wr_valid),
		.tbl_wr_key(tbl_wr_key),
		.tbl_wr_value(tbl_wr_value)
	);

	for (genvar i = 0; i < num_stages; i++) begin : stg
		match_action_stage #(
			.STAGE_ID(i)
		) stage (
			.clk(clk),
			.aresetn(aresetn),
			.phv_in_valid(stg_valid[i]),
			.phv_in(stg_phv[i]),
			.phv_out_valid(stg_valid[i+1]),
			.phv_out(stg_phv[i+1]),
			.tbl_wr_en(tbl_wr_en),
			.tbl_wr_stage(tbl_wr_stage),
			.tbl_wr_idx(tbl_wr_idx),
			.tbl_wr_valid(tbl_wr_valid),
			.tbl_wr_key(tbl_wr_key),
			.tbl_wr_value(tbl_wr_value)
		);
	end

	sync_fifo #(
		.WIDTH(word_w + 1)
	) pkt_fifo (
		.clk(clk),
		.aresetn(aresetn),
		.wr_en(pkt_wr_en),
		.wr_data(pkt_wr_data),
		.rd_en(pkt_rd_en),
		.rd_data(pkt_rd_data),
		.empty(pkt_empty),
		.nearly_full(pkt_nearly_full)
	);

	sync_fifo #(
		.WIDTH(word_w)
	) phv_fifo (
		.clk(clk),
		.aresetn(aresetn),
		.wr_en(stg_valid[num_stages]),
		.wr_data(stg_phv[num_stages]),
		.rd_en(phv_rd_en),
		.rd_data(phv_rd_data),
		.empty(phv_empty),
		.nearly_full(phv_nearly_full)
	);

	phv_deparser deparser0 (
		.clk(clk),
		.aresetn(aresetn),
		.pkt_rd_data(pkt_rd_data),
		.pkt_empty(pkt_empty),
		.pkt_rd_en(pkt_rd_en),
		.phv_rd_data(phv_rd_data),
		.phv_empty(phv_empty),
		.phv_rd_en(phv_rd_en),
		.m_axis_tdata(m_axis_tdata),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready),
		.m_axis_tlast(m_axis_tlast)
	);

endmodule

// ==== verilog/rmt_table_pkg.sv ====
package rmt_table_pkg;

	// match-action stages between filter and phv fifo
	localparam int num_stages = 2;

	// entries per match table
	localparam int tbl_depth = 8;
	localparam int tbl_idx_w = 3;

	// depth of packet fifo and phv fifo
	localparam int fifo_depth = 16;

	// nearly full once fewer entries than this are free
	// room for the phvs still travelling through the stages
	localparam int fifo_slack = 3;

endpackage

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo
	import rmt_table_pkg::*;
#(
	parameter int WIDTH = 64
) (
	input  logic clk,
	input  logic aresetn,
	input  logic wr_en,
	input  logic [WIDTH-1:0] wr_data,
	input  logic rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic empty,
	output logic nearly_full
);

	logic [WIDTH-1:0] mem [fifo_depth];
	logic [$clog2(fifo_depth)-1:0] wr_ptr;
	logic [$clog2(fifo_depth)-1:0] rd_ptr;
	// fill count, one bit wider than the pointers
	logic [$clog2(fifo_depth):0] count;
	logic do_wr;
	logic do_rd;

	// writes into a full fifo and reads from an empty one are ignored
	assign do_wr = wr_en && (count != fifo_depth);
	assign do_rd = rd_en && (count != 0);

	// show-ahead, head of the queue always on the output
	assign rd_data = mem[rd_ptr];
	assign empty = (count == 0);
	assign nearly_full = (fifo_depth - count) < fifo_slack;

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

endmodule
